// ==== apb_soc_control.f ====
hdl/soc_ctrl_pkg.sv
hdl/apb_to_reg.sv
hdl/soc_ctrl_regs.sv
hdl/llc_event_counters.sv
hdl/apb_soc_control.sv
tests/tb_apb_soc_control.sv

// ==== hdl/apb_soc_control.sv ====
// module apb_soc_control, top level joining the APB bridge, register file and LLC counters
module apb_soc_control
   import soc_ctrl_pkg::*;
(
   input  logic                            clk_i,
   input  logic                            rst_n_i,

   // APB slave
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  logic [ADDR_WIDTH-1:0]           paddr_i,
   input  logic [DATA_WIDTH-1:0]           pwdata_i,
   output logic [DATA_WIDTH-1:0]           prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,

   // LLC events
   input  logic                            llc_read_hit_cache_i,
   input  logic                            llc_read_miss_cache_i,
   input  logic                            llc_write_hit_cache_i,
   input  logic                            llc_write_miss_cache_i,

   // cluster and LLC configuration
   output logic                            cluster_ctrl_rstn_o,
   output logic                            cluster_en_sa_boot_o,
   output logic                            cluster_fetch_en_o,
   output logic [DATA_WIDTH-1:0]           llc_cache_addr_start_o,
   output logic [DATA_WIDTH-1:0]           llc_cache_addr_end_o,
   output logic [DATA_WIDTH-1:0]           llc_spm_addr_start_o,

   // auxiliary clock domain and logic locking
   output logic [CLK_SEL_WIDTH-1:0]        ot_clk_sel_o,
   output logic [DATA_WIDTH-1:0]           ot_clk_div_q_o,
   output logic                            ot_clk_div_qe_o,
   output logic                            ot_clk_gate_en_o,
   output logic [KEY_WORDS*DATA_WIDTH-1:0] key_0_o,
   output logic [KEY_WORDS*DATA_WIDTH-1:0] key_1_o
);

   logic                      reg_valid;
   logic                      reg_write;
   logic [REG_ADDR_WIDTH-1:0] reg_addr;
   logic [DATA_WIDTH-1:0]     reg_wdata;
   logic [DATA_WIDTH-1:0]     reg_rdata;
   logic                      reg_error;

   logic                      cnt_enable;
   logic [DATA_WIDTH-1:0]     cnt_read_hit;
   logic [DATA_WIDTH-1:0]     cnt_read_miss;
   logic [DATA_WIDTH-1:0]     cnt_write_hit;
   logic [DATA_WIDTH-1:0]     cnt_write_miss;

   apb_to_reg i_apb_to_reg (
      .clk_i       ( clk_i     ),
      .rst_n_i     ( rst_n_i   ),
      .psel_i      ( psel_i    ),
      .penable_i   ( penable_i ),
      .pwrite_i    ( pwrite_i  ),
      .paddr_i     ( paddr_i   ),
      .pwdata_i    ( pwdata_i  ),
      .prdata_o    ( prdata_o  ),
      .pready_o    ( pready_o  ),
      .pslverr_o   ( pslverr_o ),
      .reg_valid_o ( reg_valid ),
      .reg_write_o ( reg_write ),
      .reg_addr_o  ( reg_addr  ),
      .reg_wdata_o ( reg_wdata ),
      .reg_rdata_i ( reg_rdata ),
      .reg_error_i ( reg_error )
   );

   soc_ctrl_regs i_soc_ctrl_regs (
      .clk_i                  ( clk_i                  ),
      .rst_n_i                ( rst_n_i                ),
      .reg_valid_i            ( reg_valid              ),
      .reg_write_i            ( reg_write              ),
      .reg_addr_i             ( reg_addr               ),
      .reg_wdata_i            ( reg_wdata              ),
      .reg_rdata_o            ( reg_rdata              ),
      .reg_error_o            ( reg_error              ),
      .cnt_read_hit_i         ( cnt_read_hit           ),
      .cnt_read_miss_i        ( cnt_read_miss          ),
      .cnt_write_hit_i        ( cnt_write_hit          ),
      .cnt_write_miss_i       ( cnt_write_miss         ),
      .cluster_ctrl_rstn_o    ( cluster_ctrl_rstn_o    ),
      .cluster_en_sa_boot_o   ( cluster_en_sa_boot_o   ),
      .cluster_fetch_en_o     ( cluster_fetch_en_o     ),
      .llc_cache_addr_start_o ( llc_cache_addr_start_o ),
      .llc_cache_addr_end_o   ( llc_cache_addr_end_o   ),
      .llc_spm_addr_start_o   ( llc_spm_addr_start_o   ),
      .cnt_enable_o           ( cnt_enable             ),
      .ot_clk_sel_o           ( ot_clk_sel_o           ),
      .ot_clk_div_q_o         ( ot_clk_div_q_o         ),
      .ot_clk_div_qe_o        ( ot_clk_div_qe_o        ),
      .ot_clk_gate_en_o       ( ot_clk_gate_en_o       ),
      .key_0_o                ( key_0_o                ),
      .key_1_o                ( key_1_o                )
   );

   llc_event_counters i_llc_counters (
      .clk_i            ( clk_i                  ),
      .rst_n_i          ( rst_n_i                ),
      .enable_i         ( cnt_enable             ),
      .llc_read_hit_i   ( llc_read_hit_cache_i   ),
      .llc_read_miss_i  ( llc_read_miss_cache_i  ),
      .llc_write_hit_i  ( llc_write_hit_cache_i  ),
      .llc_write_miss_i ( llc_write_miss_cache_i ),
      .read_hit_cnt_o   ( cnt_read_hit           ),
      .read_miss_cnt_o  ( cnt_read_miss          ),
      .write_hit_cnt_o  ( cnt_write_hit          ),
      .write_miss_cnt_o ( cnt_write_miss         )
   );

endmodule

// ==== hdl/apb_to_reg.sv ====
// module apb_to_reg, APB slave FSM issuing one register request per transfer
module apb_to_reg
   import soc_ctrl_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_n_i,

   // APB slave side
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  logic [ADDR_WIDTH-1:0]     paddr_i,
   input  logic [DATA_WIDTH-1:0]     pwdata_i,
   output logic [DATA_WIDTH-1:0]     prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,

   // register port
   output logic                      reg_valid_o,
   output logic                      reg_write_o,
   output logic [REG_ADDR_WIDTH-1:0] reg_addr_o,
   output logic [DATA_WIDTH-1:0]     reg_wdata_o,
   input  logic [DATA_WIDTH-1:0]     reg_rdata_i,
   input  logic                      reg_error_i
);

   apb_state_e            state_q;
   apb_state_e            state_d;
   logic [DATA_WIDTH-1:0] prdata_q;
   logic                  pslverr_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // a setup phase moves us into the first access cycle
            if (psel_i && !penable_i) begin
               state_d = ACCESS;
            end
         end
         ACCESS: begin
            state_d = RESP;
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q   <= IDLE;
         pslverr_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         // the error flag only lives for the RESP cycle
         pslverr_q <= (state_q == ACCESS) ? reg_error_i : 1'b0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == ACCESS) begin
         prdata_q <= reg_rdata_i;
      end
   end

   // the request strobe is issued exactly once, in the first access cycle
   assign reg_valid_o = (state_q == ACCESS);
   assign reg_write_o = pwrite_i;
   assign reg_addr_o  = paddr_i[REG_ADDR_WIDTH-1:0];
   assign reg_wdata_o = pwdata_i;

   assign pready_o    = (state_q == RESP);
   assign prdata_o    = prdata_q;
   assign pslverr_o   = pslverr_q;

endmodule

// ==== hdl/llc_event_counters.sv ====
// module llc_event_counters, four enabled 32-bit LLC event counters
module llc_event_counters
   import soc_ctrl_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   // counting enable from the register file
   input  logic                  enable_i,

   // single-cycle LLC event indications
   input  logic                  llc_read_hit_i,
   input  logic                  llc_read_miss_i,
   input  logic                  llc_write_hit_i,
   input  logic                  llc_write_miss_i,

   // current counter values
   output logic [DATA_WIDTH-1:0] read_hit_cnt_o,
   output logic [DATA_WIDTH-1:0] read_miss_cnt_o,
   output logic [DATA_WIDTH-1:0] write_hit_cnt_o,
   output logic [DATA_WIDTH-1:0] write_miss_cnt_o
);

   logic [NUM_LLC_EVENTS-1:0] events;
   logic [DATA_WIDTH-1:0]     cnt_q [NUM_LLC_EVENTS];

   // event order matches the counter output order below
   assign events = {llc_write_miss_i, llc_write_hit_i, llc_read_miss_i, llc_read_hit_i};

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (enable_i) begin
         // counters wrap silently at 2^32
         for (int i = 0; i < NUM_LLC_EVENTS; i++) begin
            if (events[i]) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   assign read_hit_cnt_o   = cnt_q[0];
   assign read_miss_cnt_o  = cnt_q[1];
   assign write_hit_cnt_o  = cnt_q[2];
   assign write_miss_cnt_o = cnt_q[3];

endmodule

// ==== hdl/soc_ctrl_pkg.sv ====
// package with data and address widths, key and event counts, register map and bridge states
package soc_ctrl_pkg;

   // APB and register port widths
   localparam int unsigned DATA_WIDTH     = 32;
   localparam int unsigned ADDR_WIDTH     = 32;

   // only the low byte of the APB address is decoded
   localparam int unsigned REG_ADDR_WIDTH = 8;

   // each logic-locking key is built from this many 32-bit words
   localparam int unsigned KEY_WORDS      = 4;

   // auxiliary clock domain selector
   localparam int unsigned CLK_SEL_WIDTH  = 2;

   // read hit, read miss, write hit and write miss
   localparam int unsigned NUM_LLC_EVENTS = 4;

   // byte offsets of the control register map
   typedef enum logic [REG_ADDR_WIDTH-1:0] {
      CONTROL_CLUSTER      = 8'h00,
      LLC_CACHE_ADDR_START = 8'h04,
      LLC_CACHE_ADDR_END   = 8'h08,
      LLC_SPM_ADDR_START   = 8'h0C,
      ENABLE_LLC_COUNTERS  = 8'h10,
      LLC_READ_HIT         = 8'h14,
      LLC_READ_MISS        = 8'h18,
      LLC_WRITE_HIT        = 8'h1C,
      LLC_WRITE_MISS       = 8'h20,
      OT_CLK_SEL           = 8'h24,
      OT_CLK_DIV           = 8'h28,
      OT_CLK_GATE_EN       = 8'h2C,
      LOCK_KEY0_W0         = 8'h30,
      LOCK_KEY0_W1         = 8'h34,
      LOCK_KEY0_W2         = 8'h38,
      LOCK_KEY0_W3         = 8'h3C,
      LOCK_KEY1_W0         = 8'h40,
      LOCK_KEY1_W1         = 8'h44,
      LOCK_KEY1_W2         = 8'h48,
      LOCK_KEY1_W3         = 8'h4C
   } reg_offset_e;

   // APB bridge FSM states
   // IDLE waits for a setup phase, ACCESS issues the request, RESP answers
   typedef enum logic [1:0] {
      IDLE   = 2'b00,
      ACCESS = 2'b01,
      RESP   = 2'b10
   } apb_state_e;

endpackage

// ==== hdl/soc_ctrl_regs.sv ====
// module soc_ctrl_regs, control register file with decode, read mux and divider-update pulse
module soc_ctrl_regs
   import soc_ctrl_pkg::*;
(
   input  logic                            clk_i,
   input  logic                            rst_n_i,

   // register request and response
   input  logic                            reg_valid_i,
   input  logic                            reg_write_i,
   input  logic [REG_ADDR_WIDTH-1:0]       reg_addr_i,
   input  logic [DATA_WIDTH-1:0]           reg_wdata_i,
   output logic [DATA_WIDTH-1:0]           reg_rdata_o,
   output logic                            reg_error_o,

   // LLC event counter values
   input  logic [DATA_WIDTH-1:0]           cnt_read_hit_i,
   input  logic [DATA_WIDTH-1:0]           cnt_read_miss_i,
   input  logic [DATA_WIDTH-1:0]           cnt_write_hit_i,
   input  logic [DATA_WIDTH-1:0]           cnt_write_miss_i,

   // control outputs
   output logic                            cluster_ctrl_rstn_o,
   output logic                            cluster_en_sa_boot_o,
   output logic                            cluster_fetch_en_o,
   output logic [DATA_WIDTH-1:0]           llc_cache_addr_start_o,
   output logic [DATA_WIDTH-1:0]           llc_cache_addr_end_o,
   output logic [DATA_WIDTH-1:0]           llc_spm_addr_start_o,
   output logic                            cnt_enable_o,
   output logic [CLK_SEL_WIDTH-1:0]        ot_clk_sel_o,
   output logic [DATA_WIDTH-1:0]           ot_clk_div_q_o,
   output logic                            ot_clk_div_qe_o,
   output logic                            ot_clk_gate_en_o,
   output logic [KEY_WORDS*DATA_WIDTH-1:0] key_0_o,
   output logic [KEY_WORDS*DATA_WIDTH-1:0] key_1_o
);

   localparam int unsigned KEY_IDX_WIDTH = $clog2(KEY_WORDS);

   reg_offset_e              offset;
   logic [KEY_IDX_WIDTH-1:0] key_idx;
   logic                     wr_en;

   logic                     cluster_rstn_q;
   logic                     cluster_sa_boot_q;
   logic                     cluster_fetch_q;
   logic [DATA_WIDTH-1:0]    cache_start_q;
   logic [DATA_WIDTH-1:0]    cache_end_q;
   logic [DATA_WIDTH-1:0]    spm_start_q;
   logic                     cnt_enable_q;
   logic [CLK_SEL_WIDTH-1:0] clk_sel_q;
   logic [DATA_WIDTH-1:0]    clk_div_q;
   logic                     clk_div_qe_q;
   logic                     clk_gate_en_q;
   logic [DATA_WIDTH-1:0]    key0_q [KEY_WORDS];
   logic [DATA_WIDTH-1:0]    key1_q [KEY_WORDS];

   // bits above the word index are ignored, key words sit on consecutive words
   assign offset  = reg_offset_e'(reg_addr_i);
   assign key_idx = reg_addr_i[KEY_IDX_WIDTH+1:2];

   // read mux and error flag, unmapped or read-only writes answer with an error
   always_comb begin
      reg_rdata_o = '0;
      reg_error_o = 1'b0;
      case (offset)
         CONTROL_CLUSTER: begin
            reg_rdata_o[0] = cluster_rstn_q;
            reg_rdata_o[1] = cluster_sa_boot_q;
            reg_rdata_o[2] = cluster_fetch_q;
         end
         LLC_CACHE_ADDR_START: reg_rdata_o = cache_start_q;
         LLC_CACHE_ADDR_END:   reg_rdata_o = cache_end_q;
         LLC_SPM_ADDR_START:   reg_rdata_o = spm_start_q;
         ENABLE_LLC_COUNTERS:  reg_rdata_o[0] = cnt_enable_q;
         LLC_READ_HIT, LLC_READ_MISS, LLC_WRITE_HIT, LLC_WRITE_MISS: begin
            if (reg_write_i) begin
               reg_error_o = 1'b1;
            end else begin
               case (offset)
                  LLC_READ_HIT:  reg_rdata_o = cnt_read_hit_i;
                  LLC_READ_MISS: reg_rdata_o = cnt_read_miss_i;
                  LLC_WRITE_HIT: reg_rdata_o = cnt_write_hit_i;
                  default:       reg_rdata_o = cnt_write_miss_i;
               endcase
            end
         end
         OT_CLK_SEL:     reg_rdata_o[CLK_SEL_WIDTH-1:0] = clk_sel_q;
         OT_CLK_DIV:     reg_rdata_o = clk_div_q;
         OT_CLK_GATE_EN: reg_rdata_o[0] = clk_gate_en_q;
         LOCK_KEY0_W0, LOCK_KEY0_W1, LOCK_KEY0_W2, LOCK_KEY0_W3: begin
            reg_rdata_o = key0_q[key_idx];
         end
         LOCK_KEY1_W0, LOCK_KEY1_W1, LOCK_KEY1_W2, LOCK_KEY1_W3: begin
            reg_rdata_o = key1_q[key_idx];
         end
         default: begin
            reg_error_o = 1'b1;
         end
      endcase
   end

   assign wr_en = reg_valid_i && reg_write_i && !reg_error_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cluster_rstn_q    <= 1'b0;
         cluster_sa_boot_q <= 1'b0;
         cluster_fetch_q   <= 1'b0;
         cache_start_q     <= '0;
         cache_end_q       <= '0;
         spm_start_q       <= '0;
         cnt_enable_q      <= 1'b0;
         clk_sel_q         <= '0;
         clk_div_q         <= '0;
         clk_div_qe_q      <= 1'b0;
         clk_gate_en_q     <= 1'b0;
         for (int i = 0; i < KEY_WORDS; i++) begin
            key0_q[i] <= '0;
            key1_q[i] <= '0;
         end
      end else begin
         // divider consumers see the update pulse together with the new value
         clk_div_qe_q <= wr_en && (offset == OT_CLK_DIV);
         if (wr_en) begin
            case (offset)
               CONTROL_CLUSTER: begin
                  cluster_rstn_q    <= reg_wdata_i[0];
                  cluster_sa_boot_q <= reg_wdata_i[1];
                  cluster_fetch_q   <= reg_wdata_i[2];
               end
               LLC_CACHE_ADDR_START: cache_start_q <= reg_wdata_i;
               LLC_CACHE_ADDR_END:   cache_end_q <= reg_wdata_i;
               LLC_SPM_ADDR_START:   spm_start_q <= reg_wdata_i;
               ENABLE_LLC_COUNTERS:  cnt_enable_q <= reg_wdata_i[0];
               OT_CLK_SEL:           clk_sel_q <= reg_wdata_i[CLK_SEL_WIDTH-1:0];
               OT_CLK_DIV:           clk_div_q <= reg_wdata_i;
               OT_CLK_GATE_EN:       clk_gate_en_q <= reg_wdata_i[0];
               LOCK_KEY0_W0, LOCK_KEY0_W1, LOCK_KEY0_W2, LOCK_KEY0_W3: begin
                  key0_q[key_idx] <= reg_wdata_i;
               end
               LOCK_KEY1_W0, LOCK_KEY1_W1, LOCK_KEY1_W2, LOCK_KEY1_W3: begin
                  key1_q[key_idx] <= reg_wdata_i;
               end
               default: begin
               end
            endcase
         end
      end
   end

   assign cluster_ctrl_rstn_o    = cluster_rstn_q;
   assign cluster_en_sa_boot_o   = cluster_sa_boot_q;
   assign cluster_fetch_en_o     = cluster_fetch_q;
   assign llc_cache_addr_start_o = cache_start_q;
   assign llc_cache_addr_end_o   = cache_end_q;
   assign llc_spm_addr_start_o   = spm_start_q;
   assign cnt_enable_o           = cnt_enable_q;
   assign ot_clk_sel_o           = clk_sel_q;
   assign ot_clk_div_q_o         = clk_div_q;
   assign ot_clk_div_qe_o        = clk_div_qe_q;
   assign ot_clk_gate_en_o       = clk_gate_en_q;

   // word n of a key drives bits 32n+31 down to 32n
   for (genvar i = 0; i < KEY_WORDS; i++) begin : gen_keys
      assign key_0_o[i*DATA_WIDTH +: DATA_WIDTH] = key0_q[i];
      assign key_1_o[i*DATA_WIDTH +: DATA_WIDTH] = key1_q[i];
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the APB SoC control testbench with Verilator, run it and check the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
   -f apb_soc_control.f \
   --top-module tb_apb_soc_control \
   -o sim_tb

# The log decides the result, so a stopped run must not end the script here.
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "all tests passed" sim.log; then
   echo "simulation result: PASS"
   exit 0
else
   echo "simulation result: FAIL"
   exit 1
fi

// ==== tests/tb_apb_soc_control.sv ====
// testbench for apb_soc_control with APB driver, event stimulus, reference model and checks
module tb_apb_soc_control
   import soc_ctrl_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD    = 20;
   localparam int RESET_CYCLES  = 16;
   localparam int SEED          = 85950;
   localparam int NUM_REGS      = 20;
   localparam int REG_ROUNDS    = 4;
   localparam int KEY_ROUNDS    = 2;
   localparam int EVENT_ROUNDS  = 4;
   localparam int EVENT_CYCLES  = 40;
   localparam int ERR_TRANSFERS = 24;
   localparam int MAX_WAIT      = 4;
   localparam int NUM_TRANSFERS = 2 * NUM_REGS + REG_ROUNDS * 16 + KEY_ROUNDS * 16
                                  + EVENT_ROUNDS * 6 + ERR_TRANSFERS + 4;
   localparam int NUM_EVENT_CYCLES = EVENT_ROUNDS * 2 * (EVENT_CYCLES + 1);
   localparam int WATCHDOG_NS   = (RESET_CYCLES + (NUM_TRANSFERS + NUM_EVENT_CYCLES) * 3 + 100)
                                  * CLK_PERIOD;

   localparam reg_offset_e WRITABLE_REGS [8] = '{CONTROL_CLUSTER, LLC_CACHE_ADDR_START,
      LLC_CACHE_ADDR_END, LLC_SPM_ADDR_START, ENABLE_LLC_COUNTERS, OT_CLK_SEL, OT_CLK_DIV,
      OT_CLK_GATE_EN};

   logic                            clk_i;
   logic                            rst_n_i;
   logic                            psel_i;
   logic                            penable_i;
   logic                            pwrite_i;
   logic [ADDR_WIDTH-1:0]           paddr_i;
   logic [DATA_WIDTH-1:0]           pwdata_i;
   logic [DATA_WIDTH-1:0]           prdata_o;
   logic                            pready_o;
   logic                            pslverr_o;
   logic                            llc_read_hit_cache_i;
   logic                            llc_read_miss_cache_i;
   logic                            llc_write_hit_cache_i;
   logic                            llc_write_miss_cache_i;
   logic                            cluster_ctrl_rstn_o;
   logic                            cluster_en_sa_boot_o;
   logic                            cluster_fetch_en_o;
   logic [DATA_WIDTH-1:0]           llc_cache_addr_start_o;
   logic [DATA_WIDTH-1:0]           llc_cache_addr_end_o;
   logic [DATA_WIDTH-1:0]           llc_spm_addr_start_o;
   logic [CLK_SEL_WIDTH-1:0]        ot_clk_sel_o;
   logic [DATA_WIDTH-1:0]           ot_clk_div_q_o;
   logic                            ot_clk_div_qe_o;
   logic                            ot_clk_gate_en_o;
   logic [KEY_WORDS*DATA_WIDTH-1:0] key_0_o;
   logic [KEY_WORDS*DATA_WIDTH-1:0] key_1_o;

   // shadow of every writable register, indexed by byte offset and stored masked
   logic [DATA_WIDTH-1:0]           shadow [2**REG_ADDR_WIDTH];
   logic [DATA_WIDTH-1:0]           exp_cnt [4];
   logic                            qe_expected;

   apb_soc_control dut (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic report_failure(input string why);
      $display("Error at %0t: %s", $time, why);
      abort_run();
   endtask

   task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] actual,
                             input logic [DATA_WIDTH-1:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic actual, input logic expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected);
         abort_run();
      end
   endtask

   task automatic check_key(input string name, input logic [KEY_WORDS*DATA_WIDTH-1:0] actual,
                            input logic [KEY_WORDS*DATA_WIDTH-1:0] expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t: %s is 0x%h, expected 0x%h", $time, name, actual, expected);
         abort_run();
      end
   endtask

   function automatic logic is_mapped(input logic [REG_ADDR_WIDTH-1:0] off);
      return (off[1:0] == 2'b00) && (off <= LOCK_KEY1_W3);
   endfunction

   function automatic logic [DATA_WIDTH-1:0] field_mask(input logic [REG_ADDR_WIDTH-1:0] off);
      case (off)
         CONTROL_CLUSTER:     return 32'h0000_0007;
         ENABLE_LLC_COUNTERS: return 32'h0000_0001;
         OT_CLK_SEL:          return 32'h0000_0003;
         OT_CLK_GATE_EN:      return 32'h0000_0001;
         default:             return 32'hFFFF_FFFF;
      endcase
   endfunction

   // reference model of one transfer giving read data and error flag from the register map
   function automatic void predict(input logic write, input logic [REG_ADDR_WIDTH-1:0] off,
                                   output logic [DATA_WIDTH-1:0] data, output logic err);
      logic [REG_ADDR_WIDTH-1:0] rel;
      data = '0;
      err  = 1'b0;
      rel  = off - LLC_READ_HIT;
      if (!is_mapped(off)) begin
         err = 1'b1;
      end else if (off >= LLC_READ_HIT && off <= LLC_WRITE_MISS) begin
         if (write) begin
            err = 1'b1;
         end else begin
            data = exp_cnt[rel[3:2]];
         end
      end else if (!write) begin
         data = shadow[off];
      end
   endfunction

   function automatic logic [KEY_WORDS*DATA_WIDTH-1:0] key_value(
         input logic [REG_ADDR_WIDTH-1:0] base);
      return {shadow[base + 8'd12], shadow[base + 8'd8], shadow[base + 8'd4], shadow[base]};
   endfunction

   // one APB transfer with setup, a wait-state access cycle and the response cycle
   task automatic apb_transfer(input logic write, input logic [REG_ADDR_WIDTH-1:0] off,
                               input logic [DATA_WIDTH-1:0] wdata);
      logic [DATA_WIDTH-1:0] exp_data;
      logic                  exp_err;
      logic [31:0]           upper;
      int                    waited;
      predict(write, off, exp_data, exp_err);
      upper = $urandom();
      @(posedge clk_i);
      #2;
      psel_i      = 1'b1;
      penable_i   = 1'b0;
      pwrite_i    = write;
      paddr_i     = {upper[ADDR_WIDTH-REG_ADDR_WIDTH-1:0], off};
      pwdata_i    = wdata;
      qe_expected = 1'b0;
      @(posedge clk_i);
      #2;
      penable_i = 1'b1;
      @(negedge clk_i);
      if (pready_o) begin
         report_failure("pready_o was high in the first access cycle");
      end
      @(posedge clk_i);
      #2;
      // the write has landed at the edge that closed the first access cycle
      if (write && !exp_err) begin
         shadow[off] = wdata & field_mask(off);
         qe_expected = (off == OT_CLK_DIV);
      end
      waited = 0;
      @(negedge clk_i);
      while (!pready_o) begin
         waited++;
         if (waited >= MAX_WAIT) begin
            report_failure("pready_o did not rise to end the transfer");
         end
         @(negedge clk_i);
      end
      check_bit("pslverr_o", pslverr_o, exp_err);
      if (!write || exp_err) begin
         check_data("prdata_o", prdata_o, exp_data);
      end
   endtask

   task automatic apb_write(input logic [REG_ADDR_WIDTH-1:0] off,
                            input logic [DATA_WIDTH-1:0] data);
      apb_transfer(1'b1, off, data);
   endtask

   task automatic apb_read(input logic [REG_ADDR_WIDTH-1:0] off);
      apb_transfer(1'b0, off, '0);
   endtask

   task automatic read_all_regs();
      logic [REG_ADDR_WIDTH-1:0] off;
      off = '0;
      repeat (NUM_REGS) begin
         apb_read(off);
         off = off + 8'd4;
      end
   endtask

   // random event patterns are driven with the bus idle and counted only while enabled
   task automatic drive_events(input int cycles);
      logic [31:0] rnd;
      logic        enabled;
      enabled = shadow[ENABLE_LLC_COUNTERS][0];
      repeat (cycles) begin
         @(posedge clk_i);
         #2;
         psel_i      = 1'b0;
         penable_i   = 1'b0;
         qe_expected = 1'b0;
         rnd         = $urandom();
         {llc_write_miss_cache_i, llc_write_hit_cache_i,
          llc_read_miss_cache_i, llc_read_hit_cache_i} = rnd[3:0];
         if (enabled) begin
            exp_cnt[0] = exp_cnt[0] + {31'd0, rnd[0]};
            exp_cnt[1] = exp_cnt[1] + {31'd0, rnd[1]};
            exp_cnt[2] = exp_cnt[2] + {31'd0, rnd[2]};
            exp_cnt[3] = exp_cnt[3] + {31'd0, rnd[3]};
         end
      end
      @(posedge clk_i);
      #2;
      {llc_write_miss_cache_i, llc_write_hit_cache_i,
       llc_read_miss_cache_i, llc_read_hit_cache_i} = 4'b0000;
   endtask

   task automatic rw_writable_regs();
      logic [2:0]            idx;
      logic [DATA_WIDTH-1:0] value;
      repeat (REG_ROUNDS) begin
         idx = '0;
         repeat (8) begin
            value = $urandom();
            apb_write(WRITABLE_REGS[idx], value);
            apb_read(WRITABLE_REGS[idx]);
            idx = idx + 3'd1;
         end
      end
   endtask

   task automatic fill_key_words();
      logic [REG_ADDR_WIDTH-1:0] off;
      repeat (KEY_ROUNDS) begin
         off = LOCK_KEY0_W0;
         repeat (2 * KEY_WORDS) begin
            apb_write(off, $urandom());
            apb_read(off);
            off = off + 8'd4;
         end
      end
   endtask

   task automatic count_llc_events();
      repeat (EVENT_ROUNDS) begin
         apb_write(ENABLE_LLC_COUNTERS, 32'h0);
         drive_events(EVENT_CYCLES);
         apb_write(ENABLE_LLC_COUNTERS, 32'h1);
         drive_events(EVENT_CYCLES);
         apb_read(LLC_READ_HIT);
         apb_read(LLC_READ_MISS);
         apb_read(LLC_WRITE_HIT);
         apb_read(LLC_WRITE_MISS);
      end
   endtask

   task automatic probe_error_cases();
      logic [31:0]               rnd;
      logic [REG_ADDR_WIDTH-1:0] off;
      repeat (ERR_TRANSFERS) begin
         do begin
            rnd = $urandom();
         end while (is_mapped(rnd[REG_ADDR_WIDTH-1:0]));
         if (rnd[31]) begin
            apb_write(rnd[REG_ADDR_WIDTH-1:0], $urandom());
         end else begin
            apb_read(rnd[REG_ADDR_WIDTH-1:0]);
         end
      end
      off = LLC_READ_HIT;
      repeat (4) begin
         apb_write(off, $urandom());
         off = off + 8'd4;
      end
      read_all_regs();
   endtask

   // control outputs follow the shadow from the response cycle of each write on
   always @(negedge clk_i) begin
      if (rst_n_i) begin
         check_bit("cluster_ctrl_rstn_o", cluster_ctrl_rstn_o, shadow[CONTROL_CLUSTER][0]);
         check_bit("cluster_en_sa_boot_o", cluster_en_sa_boot_o, shadow[CONTROL_CLUSTER][1]);
         check_bit("cluster_fetch_en_o", cluster_fetch_en_o, shadow[CONTROL_CLUSTER][2]);
         check_data("llc_cache_addr_start_o", llc_cache_addr_start_o,
                    shadow[LLC_CACHE_ADDR_START]);
         check_data("llc_cache_addr_end_o", llc_cache_addr_end_o, shadow[LLC_CACHE_ADDR_END]);
         check_data("llc_spm_addr_start_o", llc_spm_addr_start_o, shadow[LLC_SPM_ADDR_START]);
         check_data("ot_clk_sel_o", {30'd0, ot_clk_sel_o}, shadow[OT_CLK_SEL]);
         check_data("ot_clk_div_q_o", ot_clk_div_q_o, shadow[OT_CLK_DIV]);
         check_bit("ot_clk_div_qe_o", ot_clk_div_qe_o, qe_expected);
         check_bit("ot_clk_gate_en_o", ot_clk_gate_en_o, shadow[OT_CLK_GATE_EN][0]);
         check_key("key_0_o", key_0_o, key_value(LOCK_KEY0_W0));
         check_key("key_1_o", key_1_o, key_value(LOCK_KEY1_W0));
      end
   end

   initial begin
      #(WATCHDOG_NS);
      report_failure("watchdog expired before the test sequence finished");
   end

   initial begin
      clk_i                  = 1'b0;
      rst_n_i                = 1'b0;
      psel_i                 = 1'b0;
      penable_i              = 1'b0;
      pwrite_i               = 1'b0;
      paddr_i                = '0;
      pwdata_i               = '0;
      llc_read_hit_cache_i   = 1'b0;
      llc_read_miss_cache_i  = 1'b0;
      llc_write_hit_cache_i  = 1'b0;
      llc_write_miss_cache_i = 1'b0;
      qe_expected            = 1'b0;
      shadow                 = '{default: '0};
      exp_cnt                = '{default: '0};
      void'($urandom(SEED));
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;
      @(negedge clk_i);
      check_bit("pready_o", pready_o, 1'b0);
      check_bit("pslverr_o", pslverr_o, 1'b0);
      read_all_regs();
      rw_writable_regs();
      fill_key_words();
      count_llc_events();
      probe_error_cases();
      $display("all tests passed");
      $finish;
   end

endmodule
